/* src.f */
+incdir+.
sld_pkg.sv
instr_sequencer.sv
lane_write_ctrl.sv
vrf_write_stage.sv
sublane_driver.sv
tb_sublane_driver.sv

/* Makefile */
TOP = tb_sublane_driver

all: run

run:
	verilator --binary --timing -f src.f --top-module $(TOP) -o Vtb
	@out=$$(./obj_dir/Vtb); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run lint clean

/* tb_sublane_ref.svh */
// Sub-lane driver reference model
`ifndef TB_SUBLANE_REF_SVH
`define TB_SUBLANE_REF_SVH

////////////////////////////////////////////////////////////
// Expected values from the element ownership rules

// Lane owns elements k*V + lane below vl
function automatic int lane_elems(input int vl, input int lane);
    if (vl <= lane) begin
        return 0;
    end
    return (vl - 1 - lane) / V + 1;
endfunction

function automatic int elem_bytes(input elem_width_e w);
    case (w)
        BYTE:    return 1;
        HALF:    return 2;
        default: return 4;
    endcase
endfunction

function automatic int read_limit_of(input int vl);
    return (vl + V - 1) / V;  // Rounded up
endfunction

// Whole words written, one address step per top byte
function automatic int words_filled(input int vl, input int lane, input elem_width_e w);
    return lane_elems(vl, lane) * elem_bytes(w) / 4;
endfunction

function automatic int addr_after(input int start, input int steps);
    return (start + steps) % DEPTH;
endfunction

// Compare and report one value
task automatic check_value(input string name, input int got, input int exp);
    if (got !== exp) begin
        err_cnt++;
        $display("FAILED %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
endtask

`endif

/* tb_sublane_driver.sv */
// Sub-lane driver testbench
`timescale 1ns/1ps

module tb_sublane_driver;
    import sld_pkg::*;

    localparam int V              = VLANE_NUM_DEF;
    localparam int DEPTH          = MEM_DEPTH_DEF;
    localparam int MAX_VL         = 300;
    localparam int MAX_DELAY      = 15;
    localparam int RUN_CYCLES     = MAX_DELAY + (MAX_VL + V - 1) / V + 12;
    localparam int NUM_RUNS       = 9;
    localparam int LOAD_BEATS     = 24;
    localparam int TIMEOUT_CYCLES = 8 + NUM_RUNS * RUN_CYCLES + LOAD_BEATS + 100;

    logic                clk_i = 1'b0;
    logic                rst_i;
    logic                start_i;
    logic                ready_o;
    vl_t                 vl_i;
    elem_width_e         wdata_width_i;
    inst_kind_e          inst_kind_i;
    ecnt_t               inst_delay_i;
    vaddr_t [2:0]        raddr_i;
    vaddr_t              waddr_i;
    logic                load_valid_i;
    logic                load_last_i;
    bwen_t [V-1:0]       load_bwen_i;
    logic                ready_for_load_o;
    logic                store_data_valid_o;
    vaddr_t [2:0]        vrf_raddr_o;
    vaddr_t [V-1:0]      vrf_waddr_o;
    bwen_t [V-1:0]       vrf_bwen_o;
    logic [V-1:0]        read_data_valid_o;

    int                  err_cnt = 0;
    int                  pass_cnt = 0;
    int                  fail_cnt = 0;
    int                  cycle_cnt = 0;
    int                  seed = 30821;
    int                  byte_cnt [V];
    int                  rdv_cnt [V];
    int                  load_waddr [V];   // Expected write address during a load
    int                  sdv_cnt;
    logic                cmp_req = 1'b0;
    inst_kind_e          cur_kind;
    int                  cur_vl;
    elem_width_e         cur_width;
    vaddr_t              cur_waddr;
    vaddr_t [2:0]        cur_raddr;
    logic                prev_rfl = 1'b0;
    logic                prev_valid;
    bwen_t [V-1:0]       prev_lbwen;

    `include "tb_sublane_ref.svh"

    sublane_driver #(
        .VLANE_NUM (V),
        .MEM_DEPTH (DEPTH)
    ) UUT (
        .clk_i                (clk_i),
        .rst_i                (rst_i),
        .start_i              (start_i),
        .ready_o              (ready_o),
        .vl_i                 (vl_i),
        .wdata_width_i        (wdata_width_i),
        .inst_kind_i          (inst_kind_i),
        .inst_delay_i         (inst_delay_i),
        .vrf_starting_raddr_i (raddr_i),
        .vrf_starting_waddr_i (waddr_i),
        .load_valid_i         (load_valid_i),
        .load_last_i          (load_last_i),
        .load_bwen_i          (load_bwen_i),
        .ready_for_load_o     (ready_for_load_o),
        .store_data_valid_o   (store_data_valid_o),
        .vrf_raddr_o          (vrf_raddr_o),
        .vrf_waddr_o          (vrf_waddr_o),
        .vrf_bwen_o           (vrf_bwen_o),
        .read_data_valid_o    (read_data_valid_o)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Monitor and comparing process, sampled at the falling edge
    always @(negedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < V; i++) begin
                byte_cnt[i] += $countones(vrf_bwen_o[i]);
                if (read_data_valid_o[i]) rdv_cnt[i]++;
            end
            if (store_data_valid_o) begin
                for (int j = 0; j < 3; j++) begin
                    check_value($sformatf("vrf_raddr_o[%0d]", j), int'(vrf_raddr_o[j]),
                                addr_after(int'(cur_raddr[j]), sdv_cnt));
                end
                sdv_cnt++;
            end
            if (prev_rfl) begin   // Load data lands one cycle later
                for (int i = 0; i < V; i++) begin
                    check_value($sformatf("vrf_bwen_o[%0d]", i), int'(vrf_bwen_o[i]),
                                prev_valid ? int'(prev_lbwen[i]) : 0);
                    check_value($sformatf("vrf_waddr_o[%0d]", i), int'(vrf_waddr_o[i]),
                                load_waddr[i]);
                    if (prev_valid && prev_lbwen[i][3]) begin
                        load_waddr[i] = addr_after(load_waddr[i], 1);   // Top byte written
                    end
                end
            end
            prev_rfl   = ready_for_load_o;
            prev_valid = load_valid_i;
            prev_lbwen = load_bwen_i;
            if (cmp_req) begin
                check_value("store_data_valid_o count", sdv_cnt,
                            (cur_kind == STORE) ? read_limit_of(cur_vl) : 0);
                for (int i = 0; i < V; i++) begin
                    check_value($sformatf("read_data_valid_o[%0d] count", i), rdv_cnt[i],
                                lane_elems(cur_vl, i));
                    if (cur_kind == NORMAL) begin
                        check_value($sformatf("vrf_bwen_o[%0d] bytes", i), byte_cnt[i],
                                    lane_elems(cur_vl, i) * elem_bytes(cur_width));
                        check_value($sformatf("vrf_waddr_o[%0d] final", i),
                                    int'(vrf_waddr_o[i]),
                                    addr_after(int'(cur_waddr),
                                               words_filled(cur_vl, i, cur_width)));
                    end
                end
                cmp_req = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    function automatic int rand_range(input int lo, input int hi);
        return lo + int'({$random(seed)} % (hi - lo + 1));
    endfunction

    function automatic elem_width_e pick_width();
        case (rand_range(0, 2))
            0:       return BYTE;
            1:       return HALF;
            default: return WORD;
        endcase
    endfunction

    // Drive one instruction and pulse start for a single edge
    task automatic send_inst(input inst_kind_e kind, input elem_width_e width,
                             input int vl, input int delay);
        @(posedge clk_i);
        cur_kind  = kind;
        cur_vl    = vl;
        cur_width = width;
        cur_waddr = vaddr_t'(rand_range(0, DEPTH - 1));
        for (int j = 0; j < 3; j++) cur_raddr[j] = vaddr_t'(rand_range(0, DEPTH - 1));
        for (int i = 0; i < V; i++) begin
            byte_cnt[i]   = 0;
            rdv_cnt[i]    = 0;
            load_waddr[i] = int'(cur_waddr);
        end
        sdv_cnt = 0;
        inst_kind_i   <= kind;
        wdata_width_i <= width;
        vl_i          <= vl_t'(vl);
        inst_delay_i  <= ecnt_t'(delay);
        raddr_i       <= cur_raddr;
        waddr_i       <= cur_waddr;
        start_i       <= 1'b1;
        @(posedge clk_i);
        start_i <= 1'b0;
    endtask

    task automatic wait_idle();
        @(negedge clk_i);
        while (ready_o) @(negedge clk_i);
        while (!ready_o) @(negedge clk_i);
    endtask

    task automatic compare_run();
        @(posedge clk_i);
        cmp_req = 1'b1;
        wait (cmp_req == 1'b0);
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("Test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("Test %s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic run_normal(input elem_width_e width, input int vl, input int delay);
        send_inst(NORMAL, width, vl, delay);
        wait_idle();
        compare_run();
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    initial begin
        int errs;
        rst_i         = 1'b0;
        start_i       = 1'b0;
        vl_i          = '0;
        wdata_width_i = WORD;
        inst_kind_i   = NORMAL;
        inst_delay_i  = '0;
        raddr_i       = '0;
        waddr_i       = '0;
        load_valid_i  = 1'b0;
        load_last_i   = 1'b0;
        load_bwen_i   = '0;
        repeat (8) @(posedge clk_i);
        rst_i <= 1'b1;

        errs = err_cnt;
        @(negedge clk_i);
        check_value("ready_o", int'(ready_o), 1);
        check_value("vrf_bwen_o", int'(vrf_bwen_o), 0);
        check_value("read_data_valid_o", int'(read_data_valid_o), 0);
        check_value("store_data_valid_o", int'(store_data_valid_o), 0);
        check_value("ready_for_load_o", int'(ready_for_load_o), 0);
        end_test("reset", errs);

        errs = err_cnt;
        for (int r = 0; r < 4; r++) begin
            run_normal(pick_width(), rand_range(1, MAX_VL), rand_range(0, MAX_DELAY));
        end
        end_test("normal random", errs);

        errs = err_cnt;
        send_inst(STORE, HALF, rand_range(1, MAX_VL), 0);
        wait_idle();
        compare_run();
        end_test("store", errs);

        // Load with gaps in load_valid_i
        errs = err_cnt;
        send_inst(LOAD, WORD, 64, 0);
        @(negedge clk_i);
        while (!ready_for_load_o) @(negedge clk_i);
        for (int b = 0; b < LOAD_BEATS; b++) begin
            @(posedge clk_i);
            load_valid_i <= (b == LOAD_BEATS - 1) || (b % 4 != 2 && rand_range(0, 3) != 0);
            load_last_i  <= (b == LOAD_BEATS - 1);
            for (int i = 0; i < V; i++) load_bwen_i[i] <= bwen_t'(rand_range(0, 15));
            @(negedge clk_i);
            check_value("ready_for_load_o", int'(ready_for_load_o), 1);
        end
        @(posedge clk_i);
        load_valid_i <= 1'b0;
        load_last_i  <= 1'b0;
        load_bwen_i  <= '0;
        @(negedge clk_i);
        check_value("ready_for_load_o", int'(ready_for_load_o), 0);
        while (!ready_o) @(negedge clk_i);
        end_test("load", errs);

        // Start pulse while busy must be dropped
        errs = err_cnt;
        send_inst(NORMAL, BYTE, 200, MAX_DELAY);
        repeat (5) @(posedge clk_i);
        inst_kind_i <= LOAD;
        vl_i        <= vl_t'(5);
        start_i     <= 1'b1;
        @(posedge clk_i);
        start_i <= 1'b0;
        wait_idle();
        compare_run();
        run_normal(HALF, 77, 3);
        end_test("start while busy", errs);

        errs = err_cnt;
        run_normal(WORD, V * 3 + 5, 2);
        run_normal(BYTE, 3, 0);
        end_test("operand read valid", errs);

        $display("Summary: %0d tests passed, %0d failed, %0d errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* sublane_driver.sv */
// Vector sub-lane driver top
`timescale 1ns/1ps

module sublane_driver #(
    parameter int VLANE_NUM = sld_pkg::VLANE_NUM_DEF,
    parameter int MEM_DEPTH = sld_pkg::MEM_DEPTH_DEF
) (
    input  logic                              clk_i,
    input  logic                              rst_i,
    // Handshake
    input  logic                              start_i,
    output logic                              ready_o,
    // Instruction fields
    input  sld_pkg::vl_t                      vl_i,
    input  sld_pkg::elem_width_e              wdata_width_i,
    input  sld_pkg::inst_kind_e               inst_kind_i,
    input  sld_pkg::ecnt_t                    inst_delay_i,
    input  sld_pkg::vaddr_t [2:0]             vrf_starting_raddr_i,
    input  sld_pkg::vaddr_t                   vrf_starting_waddr_i,
    // Load and store
    input  logic                              load_valid_i,
    input  logic                              load_last_i,
    input  sld_pkg::bwen_t [VLANE_NUM-1:0]    load_bwen_i,
    output logic                              ready_for_load_o,
    output logic                              store_data_valid_o,
    // VRF ports
    output sld_pkg::vaddr_t [2:0]             vrf_raddr_o,
    output sld_pkg::vaddr_t [VLANE_NUM-1:0]   vrf_waddr_o,
    output sld_pkg::bwen_t [VLANE_NUM-1:0]    vrf_bwen_o,
    output logic [VLANE_NUM-1:0]              read_data_valid_o
);
    import sld_pkg::*;

    inst_req_t              inst;
    lane_ctl_t              lane_ctl;
    lane_wr_t [VLANE_NUM-1:0] lane_wr;
    logic                   waddr_load;
    vaddr_t                 waddr_start;
    logic                   load_mode;

    assign inst.kind       = inst_kind_i;
    assign inst.elem_width = wdata_width_i;
    assign inst.vl         = vl_i;
    assign inst.delay      = inst_delay_i;
    assign inst.raddr      = vrf_starting_raddr_i;
    assign inst.waddr      = vrf_starting_waddr_i;

    instr_sequencer #(
        .VLANE_NUM (VLANE_NUM),
        .MEM_DEPTH (MEM_DEPTH)
    ) u_seq (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .start_i            (start_i),
        .inst_i             (inst),
        .ready_o            (ready_o),
        .load_last_i        (load_last_i),
        .ready_for_load_o   (ready_for_load_o),
        .store_data_valid_o (store_data_valid_o),
        .raddr_o            (vrf_raddr_o),
        .lane_ctl_o         (lane_ctl),
        .waddr_load_o       (waddr_load),
        .waddr_start_o      (waddr_start),
        .load_mode_o        (load_mode)
    );

    ////////////////////////////////////////////////////////////
    // One control slice per lane
    for (genvar i = 0; i < VLANE_NUM; i++) begin : g_lane
        lane_write_ctrl #(
            .VLANE_NUM (VLANE_NUM),
            .LANE_IDX  (i)
        ) u_lane (
            .clk_i  (clk_i),
            .rst_i  (rst_i),
            .ctl_i  (lane_ctl),
            .lane_o (lane_wr[i])
        );
    end

    vrf_write_stage #(
        .VLANE_NUM (VLANE_NUM),
        .MEM_DEPTH (MEM_DEPTH)
    ) u_wr_stage (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .lanes_i           (lane_wr),
        .waddr_load_i      (waddr_load),
        .waddr_start_i     (waddr_start),
        .load_mode_i       (load_mode),
        .load_valid_i      (load_valid_i),
        .load_bwen_i       (load_bwen_i),
        .vrf_waddr_o       (vrf_waddr_o),
        .vrf_bwen_o        (vrf_bwen_o),
        .read_data_valid_o (read_data_valid_o)
    );

endmodule

/* vrf_write_stage.sv */
// VRF write port stage
`timescale 1ns/1ps

module vrf_write_stage #(
    parameter int VLANE_NUM = sld_pkg::VLANE_NUM_DEF,
    parameter int MEM_DEPTH = sld_pkg::MEM_DEPTH_DEF
) (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  sld_pkg::lane_wr_t [VLANE_NUM-1:0]     lanes_i,
    input  logic                                  waddr_load_i,
    input  sld_pkg::vaddr_t                       waddr_start_i,
    input  logic                                  load_mode_i,
    input  logic                                  load_valid_i,
    input  sld_pkg::bwen_t [VLANE_NUM-1:0]        load_bwen_i,
    output sld_pkg::vaddr_t [VLANE_NUM-1:0]       vrf_waddr_o,
    output sld_pkg::bwen_t [VLANE_NUM-1:0]        vrf_bwen_o,
    output logic [VLANE_NUM-1:0]                  read_data_valid_o
);
    import sld_pkg::*;

    bwen_t  [VLANE_NUM-1:0] bwen_d, bwen_q;
    vaddr_t [VLANE_NUM-1:0] waddr_q;
    logic   [VLANE_NUM-1:0] rd_valid_d, rd_valid_q;

    ////////////////////////////////////////////////////////////
    // Byte enable source select
    always_comb begin
        for (int i = 0; i < VLANE_NUM; i++) begin
            if (load_mode_i) begin
                bwen_d[i] = load_valid_i ? load_bwen_i[i] : '0;   // No write in a gap
            end else begin
                bwen_d[i] = lanes_i[i].bwen;
            end
            rd_valid_d[i] = lanes_i[i].rd_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            bwen_q     <= '0;
            rd_valid_q <= '0;
        end else begin
            bwen_q     <= bwen_d;
            rd_valid_q <= rd_valid_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // Write address per lane
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < VLANE_NUM; i++) begin
            if (waddr_load_i) begin
                waddr_q[i] <= waddr_start_i;
            end else if (bwen_q[i][3]) begin
                waddr_q[i] <= vaddr_next(waddr_q[i], MEM_DEPTH);  // Top byte done
            end
        end
    end

    assign vrf_waddr_o       = waddr_q;
    assign vrf_bwen_o        = bwen_q;
    assign read_data_valid_o = rd_valid_q;

endmodule

/* lane_write_ctrl.sv */
// Per-lane write and read valid control
`timescale 1ns/1ps

module lane_write_ctrl #(
    parameter int VLANE_NUM = sld_pkg::VLANE_NUM_DEF,
    parameter int LANE_IDX  = 0
) (
    input  logic               clk_i,
    input  logic               rst_i,
    input  sld_pkg::lane_ctl_t ctl_i,
    output sld_pkg::lane_wr_t  lane_o
);
    import sld_pkg::*;

    localparam int IDX_W = $bits(ecnt_t) + $bits(vl_t);

    ecnt_t            wr_cnt_q, rd_cnt_q;
    bwen_t            rot_q;
    bwen_t            rot_init, rot_step;
    logic [IDX_W-1:0] wr_idx, rd_idx;

    // Global element index owned by this lane
    assign wr_idx = IDX_W'(wr_cnt_q) * IDX_W'(VLANE_NUM) + IDX_W'(LANE_IDX);
    assign rd_idx = IDX_W'(rd_cnt_q) * IDX_W'(VLANE_NUM) + IDX_W'(LANE_IDX);

    // Byte enable pattern by element width
    always_comb begin
        case (ctl_i.elem_width)
            BYTE: begin
                rot_init = 4'b0001;
                rot_step = {rot_q[2:0], rot_q[3]};
            end
            HALF: begin
                rot_init = 4'b0011;
                rot_step = {rot_q[1:0], rot_q[3:2]};
            end
            WORD: begin
                rot_init = 4'b1111;
                rot_step = rot_q;
            end
            default: begin
                rot_init = 4'b0000;
                rot_step = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wr_cnt_q <= '0;
            rd_cnt_q <= '0;
            rot_q    <= '0;
        end else if (ctl_i.restart) begin
            wr_cnt_q <= '0;
            rd_cnt_q <= '0;
            rot_q    <= rot_init;
        end else begin
            if (ctl_i.write_step) begin
                wr_cnt_q <= wr_cnt_q + 1'b1;
                rot_q    <= rot_step;
            end
            if (ctl_i.read_step) begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end
        end
    end

    assign lane_o.bwen     = (ctl_i.write_en && wr_idx < IDX_W'(ctl_i.vl)) ? rot_q : '0;
    assign lane_o.rd_valid = ctl_i.read_step && (rd_idx < IDX_W'(ctl_i.vl));

endmodule

/* instr_sequencer.sv */
// Instruction sequencer
`timescale 1ns/1ps

module instr_sequencer #(
    parameter int VLANE_NUM = sld_pkg::VLANE_NUM_DEF,
    parameter int MEM_DEPTH = sld_pkg::MEM_DEPTH_DEF
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    start_i,
    input  sld_pkg::inst_req_t      inst_i,
    output logic                    ready_o,
    input  logic                    load_last_i,
    output logic                    ready_for_load_o,
    output logic                    store_data_valid_o,
    output sld_pkg::vaddr_t [2:0]   raddr_o,
    output sld_pkg::lane_ctl_t      lane_ctl_o,
    output logic                    waddr_load_o,
    output sld_pkg::vaddr_t         waddr_start_o,
    output logic                    load_mode_o
);
    import sld_pkg::*;

    localparam int CW  = $bits(ecnt_t) + 1;   // Covers delay plus read_limit
    localparam int VLW = $bits(vl_t) + 1;

    ////////////////////////////////////////////////////////////
    // Declarations
    seq_state_e   state_q, state_d;
    inst_req_t    inst_q;
    logic         pending_q;                  // Capture cycle marker
    logic         ready_q;
    logic         accept;
    logic [CW-1:0] cnt_q;
    logic [CW-1:0] exec_last;
    logic [VLW-1:0] vl_round;
    ecnt_t        read_limit;
    logic         rd_active;
    logic         wr_window;
    vaddr_t [2:0] raddr_q;

    assign accept = start_i && ready_q;
    assign ready_o = ready_q;

    // Elements per lane, rounded up
    assign vl_round   = {1'b0, inst_q.vl} + VLW'(VLANE_NUM - 1);
    assign read_limit = ecnt_t'(vl_round >> $clog2(VLANE_NUM));
    assign exec_last  = CW'(inst_q.delay) + CW'(read_limit);

    assign rd_active = (state_q == ST_EXEC || state_q == ST_READ) &&
                       (cnt_q < CW'(read_limit));
    assign wr_window = (state_q == ST_EXEC) && (cnt_q >= CW'(inst_q.delay)) &&
                       (cnt_q < exec_last);

    ////////////////////////////////////////////////////////////
    // Mode FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (pending_q) begin
                    case (inst_q.kind)
                        NORMAL:  state_d = ST_EXEC;
                        STORE:   state_d = ST_READ;
                        LOAD:    state_d = ST_LOAD;
                        default: state_d = ST_IDLE;   // Unknown kind is dropped
                    endcase
                end
            end
            ST_EXEC: if (cnt_q == exec_last) state_d = ST_IDLE;
            ST_READ: if (cnt_q + 1'b1 >= CW'(read_limit)) state_d = ST_IDLE;
            ST_LOAD: if (load_last_i) state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q   <= ST_IDLE;
            pending_q <= 1'b0;
            ready_q   <= 1'b1;
            cnt_q     <= '0;
        end else begin
            state_q   <= state_d;
            pending_q <= accept;
            if (accept) begin
                ready_q <= 1'b0;
            end else if (state_q == ST_IDLE && !pending_q && !ready_q) begin
                ready_q <= 1'b1;                  // One cycle after return to idle
            end
            if (state_q == ST_IDLE) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Instruction capture and operand read addresses
    always_ff @(posedge clk_i) begin
        if (accept) begin
            inst_q <= inst_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pending_q) begin
            raddr_q <= inst_q.raddr;
        end else if (rd_active) begin
            for (int j = 0; j < 3; j++) begin
                raddr_q[j] <= vaddr_next(raddr_q[j], MEM_DEPTH);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    assign raddr_o            = raddr_q;
    assign store_data_valid_o = (state_q == ST_READ);
    assign ready_for_load_o   = (state_q == ST_LOAD);
    assign load_mode_o        = (state_q == ST_LOAD);
    assign waddr_load_o       = pending_q;
    assign waddr_start_o      = inst_q.waddr;

    assign lane_ctl_o.write_en   = wr_window;
    assign lane_ctl_o.write_step = wr_window;
    assign lane_ctl_o.read_step  = rd_active;
    assign lane_ctl_o.restart    = pending_q;  // Lanes rewind during capture
    assign lane_ctl_o.elem_width = inst_q.elem_width;
    assign lane_ctl_o.vl         = inst_q.vl;

endmodule

/* sld_pkg.sv */
// Sub-lane driver shared definitions
package sld_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    localparam int VLANE_NUM_DEF       = 8;
    localparam int MEM_DEPTH_DEF       = 512;
    localparam int MAX_VL_PER_LANE_DEF = 256;

    ////////////////////////////////////////////////////////////
    // Vector types
    typedef logic [$clog2(MEM_DEPTH_DEF)-1:0]                     vaddr_t;  // VRF location
    typedef logic [$clog2(VLANE_NUM_DEF*MAX_VL_PER_LANE_DEF)-1:0] vl_t;
    typedef logic [3:0]                                           bwen_t;   // One 32-bit word
    typedef logic [$clog2(MAX_VL_PER_LANE_DEF):0]                 ecnt_t;   // Per-lane count

    typedef enum logic [1:0] {BYTE = 2'd1, HALF = 2'd2, WORD = 2'd3} elem_width_e;
    typedef enum logic [1:0] {NORMAL = 2'd0, STORE = 2'd1, LOAD = 2'd2} inst_kind_e;
    typedef enum logic [1:0] {ST_IDLE, ST_EXEC, ST_READ, ST_LOAD} seq_state_e;

    ////////////////////////////////////////////////////////////
    // Packed structs
    typedef struct packed {
        inst_kind_e  kind;
        elem_width_e elem_width;
        vl_t         vl;
        ecnt_t       delay;       // Pipeline delay before writes
        vaddr_t [2:0] raddr;      // Operand start locations
        vaddr_t      waddr;
    } inst_req_t;

    // Broadcast to every lane each cycle
    typedef struct packed {
        logic        write_en;
        logic        write_step;
        logic        read_step;
        logic        restart;
        elem_width_e elem_width;
        vl_t         vl;
    } lane_ctl_t;

    typedef struct packed {
        bwen_t bwen;
        logic  rd_valid;
    } lane_wr_t;

    // Next location, wrapping at the end of the lane memory
    function automatic vaddr_t vaddr_next(input vaddr_t addr, input int unsigned depth);
        return (addr == vaddr_t'(depth - 1)) ? '0 : vaddr_t'(addr + 1'b1);
    endfunction

endpackage
